//--- mtrap_macros.svh
`ifndef MTRAP_MACROS_SVH
`define MTRAP_MACROS_SVH

`define XLEN        32
`define CSR_ADDR_W  12

// Machine CSR addresses
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344

// Read-only identity values
`define MVENDORID_VAL  32'h0000_0000
`define MARCHID_VAL    32'h0000_0000
`define MIMPID_VAL     32'h0000_0001
`define MHARTID_VAL    32'h0000_0000
`define MISA_VAL       32'h4000_0100  // RV32I

`define MTVEC_RESET    32'h0000_0100

`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7

// Shared by mie and mip
`define MIE_MSIE_BIT  3
`define MIE_MTIE_BIT  7
`define MIE_MEIE_BIT  11

`define CAUSE_FETCH_MISALIGN  32'd0
`define CAUSE_LOAD_MISALIGN   32'd4
`define CAUSE_STORE_MISALIGN  32'd6
`define CAUSE_IRQ_SW          32'd3
`define CAUSE_IRQ_TIMER       32'd7
`define CAUSE_IRQ_EXT         32'd11
`define CAUSE_IRQ_FLAG        31

`endif

//--- mtrap_pkg.sv
`include "mtrap_macros.svh"

package mtrap_pkg;

  // Vectors with a meaning
  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [4:0]             uimm_t;  // Zero-extended CSR immediate

  // CSR read-modify-write flavour
  typedef enum logic [1:0] {
    WMODE_WRITE,
    WMODE_SET,
    WMODE_CLEAR
  } csr_wmode_e;

  // What the trap controller decided this cycle
  typedef enum logic [1:0] {
    TRAP_NONE,
    TRAP_EXC,
    TRAP_IRQ,
    TRAP_MRET
  } trap_kind_e;

endpackage

//--- csr_instr_decoder.sv
`timescale 1ns/10ps

module csr_instr_decoder import mtrap_pkg::*; (
  input  logic       instr_valid_i,
  input  word_t      instr_i,
  input  word_t      rs1_data_i,
  output logic       csr_access_o,
  output csr_addr_t  csr_addr_o,
  output csr_wmode_e csr_wmode_o,
  output word_t      csr_wdata_o,
  output logic       csr_we_o,
  output logic       mret_o
);

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam word_t      INSTR_MRET = 32'h3020_0073;

  logic       is_system;
  logic [2:0] funct3;
  uimm_t      rs1_field;  // rs1 index or uimm
  logic       csr_op;
  logic       no_write;

  assign is_system = (instr_i[6:0] == OPC_SYSTEM);
  assign funct3    = instr_i[14:12];
  assign rs1_field = instr_i[19:15];
  assign csr_op    = is_system && (funct3[1:0] != 2'b00);  // Skips 000 and 100

  assign csr_access_o = instr_valid_i & csr_op;
  assign csr_addr_o   = instr_i[31:20];
  assign csr_wdata_o  = funct3[2] ? word_t'(rs1_field) : rs1_data_i;
  assign mret_o       = instr_valid_i & (instr_i == INSTR_MRET);

  always_comb begin
    case (funct3[1:0])
      2'b10:   csr_wmode_o = WMODE_SET;
      2'b11:   csr_wmode_o = WMODE_CLEAR;
      default: csr_wmode_o = WMODE_WRITE;
    endcase
  end

  // Zero source field means read only
  always_comb begin
    if (funct3[2]) begin
      no_write = (rs1_field == '0);                               // Any immediate form
    end else begin
      no_write = (rs1_field == '0) && (funct3[1:0] != 2'b01);     // csrrs, csrrc
    end
  end

  assign csr_we_o = csr_access_o & ~no_write;

endmodule

//--- trap_ctrl.sv
`timescale 1ns/10ps
`include "mtrap_macros.svh"

module trap_ctrl import mtrap_pkg::*; (
  input  logic       instr_valid_i,
  input  logic       fetch_exc_i,
  input  logic       lsu_exc_i,
  input  logic       lsu_store_i,
  input  logic       mret_i,
  input  word_t      fetch_tval_i,
  input  word_t      lsu_tval_i,
  input  word_t      mip_i,
  input  word_t      mie_i,
  input  logic       mstatus_mie_i,
  output trap_kind_e trap_kind_o,
  output word_t      trap_cause_o,
  output word_t      trap_tval_o
);

  localparam word_t IRQ_FLAG = word_t'(1) << `CAUSE_IRQ_FLAG;

  word_t irq_pend;
  logic  irq_allowed;

  assign irq_pend = mip_i & mie_i;

  // Interrupts only in an idle cycle with global enable set
  assign irq_allowed = mstatus_mie_i & ~instr_valid_i & ~fetch_exc_i & ~lsu_exc_i;

  ////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////
  always_comb begin
    trap_kind_o  = TRAP_NONE;
    trap_cause_o = '0;
    trap_tval_o  = '0;
    if (fetch_exc_i) begin
      trap_kind_o  = TRAP_EXC;
      trap_cause_o = `CAUSE_FETCH_MISALIGN;
      trap_tval_o  = fetch_tval_i;  // Faulting target
    end else if (lsu_exc_i) begin
      trap_kind_o  = TRAP_EXC;
      trap_cause_o = lsu_store_i ? `CAUSE_STORE_MISALIGN : `CAUSE_LOAD_MISALIGN;
      trap_tval_o  = lsu_tval_i;
    end else if (mret_i) begin
      trap_kind_o = TRAP_MRET;
    end else if (irq_allowed) begin
      // External first, then software, then timer
      if (irq_pend[`MIE_MEIE_BIT]) begin
        trap_kind_o  = TRAP_IRQ;
        trap_cause_o = `CAUSE_IRQ_EXT | IRQ_FLAG;
      end else if (irq_pend[`MIE_MSIE_BIT]) begin
        trap_kind_o  = TRAP_IRQ;
        trap_cause_o = `CAUSE_IRQ_SW | IRQ_FLAG;
      end else if (irq_pend[`MIE_MTIE_BIT]) begin
        trap_kind_o  = TRAP_IRQ;
        trap_cause_o = `CAUSE_IRQ_TIMER | IRQ_FLAG;
      end
    end
  end

endmodule

//--- machine_csr_file.sv
`timescale 1ns/10ps
`include "mtrap_macros.svh"

module machine_csr_file import mtrap_pkg::*; (
  input  logic       clk_i,
  input  logic       rstn_i,
  input  logic       csr_access_i,
  input  logic       csr_we_i,
  input  csr_addr_t  csr_addr_i,
  input  csr_wmode_e csr_wmode_i,
  input  word_t      csr_wdata_i,
  input  word_t      pc_i,
  input  trap_kind_e trap_kind_i,
  input  word_t      trap_cause_i,
  input  word_t      trap_tval_i,
  input  logic       sw_irq_i,
  input  logic       timer_irq_i,
  input  logic       ext_irq_i,
  output word_t      mip_o,
  output word_t      mie_o,
  output logic       mstatus_mie_o,
  output word_t      rdata_o,
  output logic       rdata_valid_o,
  output logic       trap_o,
  output word_t      trap_addr_o
);

  localparam word_t MTVEC_RST = `MTVEC_RESET;

  logic               mstatus_mie_r;
  logic               mstatus_mpie_r;
  logic [`XLEN-1:2]   mtvec_base_r;   // Direct mode only
  logic               mip_msip_r;
  logic               mip_mtip_r;
  logic               mip_meip_r;
  logic               mie_msie_r;
  logic               mie_mtie_r;
  logic               mie_meie_r;
  word_t              mscratch_r;
  word_t              mepc_r;
  word_t              mcause_r;
  word_t              mtval_r;

  word_t mstatus_word;
  word_t mip_word;
  word_t mie_word;
  word_t rd_val;
  word_t wr_val;
  logic  wr_en;
  logic  take_trap;
  logic  do_mret;

  // Assemble sparse registers into full words
  always_comb begin
    mstatus_word = '0;
    mstatus_word[`MSTATUS_MIE_BIT]  = mstatus_mie_r;
    mstatus_word[`MSTATUS_MPIE_BIT] = mstatus_mpie_r;
    mip_word = '0;
    mip_word[`MIE_MSIE_BIT] = mip_msip_r;
    mip_word[`MIE_MTIE_BIT] = mip_mtip_r;
    mip_word[`MIE_MEIE_BIT] = mip_meip_r;
    mie_word = '0;
    mie_word[`MIE_MSIE_BIT] = mie_msie_r;
    mie_word[`MIE_MTIE_BIT] = mie_mtie_r;
    mie_word[`MIE_MEIE_BIT] = mie_meie_r;
  end

  assign mip_o         = mip_word;
  assign mie_o         = mie_word;
  assign mstatus_mie_o = mstatus_mie_r;

  ////////////////////////////////////////////////////////////
  // Read mux and modify
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (csr_addr_i)
      `CSR_ADDR_MVENDORID: rd_val = `MVENDORID_VAL;
      `CSR_ADDR_MARCHID:   rd_val = `MARCHID_VAL;
      `CSR_ADDR_MIMPID:    rd_val = `MIMPID_VAL;
      `CSR_ADDR_MHARTID:   rd_val = `MHARTID_VAL;
      `CSR_ADDR_MISA:      rd_val = `MISA_VAL;
      `CSR_ADDR_MSTATUS:   rd_val = mstatus_word;
      `CSR_ADDR_MTVEC:     rd_val = {mtvec_base_r, 2'b00};
      `CSR_ADDR_MIP:       rd_val = mip_word;
      `CSR_ADDR_MIE:       rd_val = mie_word;
      `CSR_ADDR_MSCRATCH:  rd_val = mscratch_r;
      `CSR_ADDR_MEPC:      rd_val = mepc_r;
      `CSR_ADDR_MCAUSE:    rd_val = mcause_r;
      `CSR_ADDR_MTVAL:     rd_val = mtval_r;
      default:             rd_val = '0;
    endcase
  end

  always_comb begin
    case (csr_wmode_i)
      WMODE_SET:   wr_val = rd_val | csr_wdata_i;
      WMODE_CLEAR: wr_val = rd_val & ~csr_wdata_i;
      default:     wr_val = csr_wdata_i;
    endcase
  end

  assign take_trap = (trap_kind_i == TRAP_EXC) || (trap_kind_i == TRAP_IRQ);
  assign do_mret   = (trap_kind_i == TRAP_MRET);
  assign wr_en     = csr_access_i & csr_we_i & (trap_kind_i == TRAP_NONE);

  ////////////////////////////////////////////////////////////
  // CSR state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mstatus_mie_r  <= 1'b0;
      mstatus_mpie_r <= 1'b0;
      mtvec_base_r   <= MTVEC_RST[`XLEN-1:2];
      mip_msip_r     <= 1'b0;
      mip_mtip_r     <= 1'b0;
      mip_meip_r     <= 1'b0;
      mie_msie_r     <= 1'b0;
      mie_mtie_r     <= 1'b0;
      mie_meie_r     <= 1'b0;
      mscratch_r     <= '0;
      mepc_r         <= '0;
      mcause_r       <= '0;
      mtval_r        <= '0;
    end else begin
      mip_msip_r <= sw_irq_i;      // Pending follows the lines
      mip_mtip_r <= timer_irq_i;
      mip_meip_r <= ext_irq_i;
      if (take_trap) begin
        mepc_r         <= pc_i;
        mcause_r       <= trap_cause_i;
        mtval_r        <= trap_tval_i;
        mstatus_mpie_r <= mstatus_mie_r;
        mstatus_mie_r  <= 1'b0;
      end else if (do_mret) begin
        mstatus_mie_r  <= mstatus_mpie_r;
        mstatus_mpie_r <= 1'b1;
      end else if (wr_en) begin
        case (csr_addr_i)
          `CSR_ADDR_MSTATUS: begin
            mstatus_mie_r  <= wr_val[`MSTATUS_MIE_BIT];
            mstatus_mpie_r <= wr_val[`MSTATUS_MPIE_BIT];
          end
          `CSR_ADDR_MTVEC: mtvec_base_r <= wr_val[`XLEN-1:2];
          `CSR_ADDR_MIE: begin
            mie_msie_r <= wr_val[`MIE_MSIE_BIT];
            mie_mtie_r <= wr_val[`MIE_MTIE_BIT];
            mie_meie_r <= wr_val[`MIE_MEIE_BIT];
          end
          `CSR_ADDR_MSCRATCH: mscratch_r <= wr_val;
          `CSR_ADDR_MEPC:     mepc_r     <= wr_val;
          `CSR_ADDR_MCAUSE:   mcause_r   <= wr_val;
          `CSR_ADDR_MTVAL:    mtval_r    <= wr_val;
          default: ;  // Read-only or unknown
        endcase
      end
    end
  end

  // Read return and fetch redirect
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rdata_o       <= '0;
      rdata_valid_o <= 1'b0;
      trap_o        <= 1'b0;
      trap_addr_o   <= '0;
    end else begin
      rdata_valid_o <= csr_access_i;
      if (csr_access_i) begin
        rdata_o <= rd_val;  // Value before the write
      end
      trap_o <= (trap_kind_i != TRAP_NONE);
      case (trap_kind_i)
        TRAP_EXC, TRAP_IRQ: trap_addr_o <= {mtvec_base_r, 2'b00};
        TRAP_MRET:          trap_addr_o <= mepc_r;
        default:            trap_addr_o <= '0;
      endcase
    end
  end

endmodule

//--- mtrap_top.sv
`timescale 1ns/10ps

module mtrap_top import mtrap_pkg::*; (
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  instr_valid_i,
  input  word_t instr_i,
  input  word_t rs1_data_i,
  input  word_t pc_i,
  input  logic  fetch_exc_i,
  input  word_t fetch_tval_i,
  input  logic  lsu_exc_i,
  input  word_t lsu_tval_i,
  input  logic  lsu_store_i,
  input  logic  sw_irq_i,
  input  logic  timer_irq_i,
  input  logic  ext_irq_i,
  output word_t rdata_o,
  output logic  rdata_valid_o,
  output logic  trap_o,
  output word_t trap_addr_o
);

  // Decoder to CSR file
  logic       csr_access;
  csr_addr_t  csr_addr;
  csr_wmode_e csr_wmode;
  word_t      csr_wdata;
  logic       csr_we;
  logic       mret_req;

  // Trap controller loop
  trap_kind_e trap_kind;
  word_t      trap_cause;
  word_t      trap_tval;
  word_t      mip_bits;
  word_t      mie_bits;
  logic       mstatus_mie;

  csr_instr_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .csr_access_o  (csr_access),
    .csr_addr_o    (csr_addr),
    .csr_wmode_o   (csr_wmode),
    .csr_wdata_o   (csr_wdata),
    .csr_we_o      (csr_we),
    .mret_o        (mret_req)
  );

  trap_ctrl u_trap_ctrl (
    .instr_valid_i (instr_valid_i),
    .fetch_exc_i   (fetch_exc_i),
    .lsu_exc_i     (lsu_exc_i),
    .lsu_store_i   (lsu_store_i),
    .mret_i        (mret_req),
    .fetch_tval_i  (fetch_tval_i),
    .lsu_tval_i    (lsu_tval_i),
    .mip_i         (mip_bits),
    .mie_i         (mie_bits),
    .mstatus_mie_i (mstatus_mie),
    .trap_kind_o   (trap_kind),
    .trap_cause_o  (trap_cause),
    .trap_tval_o   (trap_tval)
  );

  machine_csr_file u_csr_file (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .csr_access_i  (csr_access),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wmode_i   (csr_wmode),
    .csr_wdata_i   (csr_wdata),
    .pc_i          (pc_i),
    .trap_kind_i   (trap_kind),
    .trap_cause_i  (trap_cause),
    .trap_tval_i   (trap_tval),
    .sw_irq_i      (sw_irq_i),
    .timer_irq_i   (timer_irq_i),
    .ext_irq_i     (ext_irq_i),
    .mip_o         (mip_bits),
    .mie_o         (mie_bits),
    .mstatus_mie_o (mstatus_mie),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o),
    .trap_o        (trap_o),
    .trap_addr_o   (trap_addr_o)
  );

endmodule

//--- mtrap_clkgen.sv
`timescale 1ns/10ps

module mtrap_clkgen (
  output logic clk_o,
  output logic rstn_o
);

  localparam time HALF_PERIOD = 4ns;  // 8 ns clock
  localparam int  RST_CYCLES  = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release just after an edge
  initial begin
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rstn_o = 1'b1;
  end

endmodule

//--- mtrap_checker.sv
`timescale 1ns/10ps

module mtrap_checker import mtrap_pkg::*; (
  input logic  clk_i,
  input logic  rstn_i,
  input logic  csr_access_i,
  input logic  rdata_valid_i,
  input logic  trap_i,
  input word_t rdata_i,
  input word_t trap_addr_i
);

  // Redirect is a single pulse
  trap_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
    trap_i |=> !trap_i)
    else $error("trap_o stayed high for two cycles");

  // Every CSR access returns data one cycle later
  read_return: assert property (@(posedge clk_i) disable iff (!rstn_i)
    csr_access_i |=> rdata_valid_i)
    else $error("rdata_valid_o missing after a CSR access");

  read_origin: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rdata_valid_i |-> $past(csr_access_i))
    else $error("rdata_valid_o without a CSR access");

  outputs_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !$isunknown({rdata_i, rdata_valid_i, trap_i, trap_addr_i}))
    else $error("Unknown value on a top-level output");

endmodule

bind mtrap_top mtrap_checker u_checker (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .csr_access_i  (csr_access),
  .rdata_valid_i (rdata_valid_o),
  .trap_i        (trap_o),
  .rdata_i       (rdata_o),
  .trap_addr_i   (trap_addr_o)
);

//--- tb_mtrap.sv
`timescale 1ns/10ps

module tb_mtrap import mtrap_pkg::*; ();

  localparam int TRAP_TIMEOUT = 20;  // Cycles
  localparam int RST_TIMEOUT  = 20;
  localparam int IRQ_LATENCY  = 2;   // Line to trap_o, mip stage plus trap stage

  logic  clk;
  logic  rstn;
  logic  instr_valid;
  word_t instr;
  word_t rs1_data;
  word_t pc;
  logic  fetch_exc;
  word_t fetch_tval;
  logic  lsu_exc;
  word_t lsu_tval;
  logic  lsu_store;
  logic  sw_irq;
  logic  timer_irq;
  logic  ext_irq;
  word_t rdata;
  logic  rdata_valid;
  logic  trap;
  word_t trap_addr;

  // Fields of the current record
  string op;
  word_t rec_instr;
  word_t rec_rs1;
  word_t rec_pc;
  word_t rec_tval;
  word_t rec_flags;
  word_t exp_rdata;
  word_t exp_trap;
  word_t exp_addr;

  mtrap_clkgen u_clkgen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  mtrap_top u_mtrap_top (
    .clk_i         (clk),
    .rstn_i        (rstn),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .rs1_data_i    (rs1_data),
    .pc_i          (pc),
    .fetch_exc_i   (fetch_exc),
    .fetch_tval_i  (fetch_tval),
    .lsu_exc_i     (lsu_exc),
    .lsu_tval_i    (lsu_tval),
    .lsu_store_i   (lsu_store),
    .sw_irq_i      (sw_irq),
    .timer_irq_i   (timer_irq),
    .ext_irq_i     (ext_irq),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid),
    .trap_o        (trap),
    .trap_addr_o   (trap_addr)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive and sample off the edge
  endtask

  task automatic idle_inputs();
    instr_valid = 1'b0;
    instr       = '0;
    rs1_data    = '0;
    fetch_exc   = 1'b0;
    fetch_tval  = '0;
    lsu_exc     = 1'b0;
    lsu_tval    = '0;
    lsu_store   = 1'b0;
  endtask

  // One-cycle strobe with the result due in the next cycle
  task automatic run_strobe();
    if (op == "instr" || rec_instr != '0) begin
      instr_valid = 1'b1;
      instr       = rec_instr;
      rs1_data    = rec_rs1;
    end
    if (op == "fexc") begin
      fetch_exc  = 1'b1;
      fetch_tval = rec_tval;
    end
    if (op == "lexc") begin
      lsu_exc   = 1'b1;
      lsu_tval  = rec_tval;
      lsu_store = rec_flags[1];
    end
    pc = rec_pc;
    next_cycle();
    idle_inputs();
    if (rec_flags[0]) begin
      check_word("rdata_valid_o", word_t'(rdata_valid), 32'h1);
      check_word("rdata_o", rdata, exp_rdata);
    end
    check_word("trap_o", word_t'(trap), exp_trap);
    if (exp_trap[0]) check_word("trap_addr_o", trap_addr, exp_addr);
  endtask

  task automatic run_irq();
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    {ext_irq, timer_irq, sw_irq} = rec_flags[2:0];
    pc = rec_pc;
    while (!seen && waited < TRAP_TIMEOUT) begin
      next_cycle();
      seen   = trap;
      waited = waited + 1;
    end
    {ext_irq, timer_irq, sw_irq} = 3'b000;  // Lines back to idle
    if (exp_trap[0]) begin
      assert (seen) else begin
        $display("No trap within %0d cycles of raising the interrupt lines", TRAP_TIMEOUT);
        abort_run();
      end
      assert (waited == IRQ_LATENCY) else begin
        $display("Interrupt trap came after %0d cycles instead of %0d", waited, IRQ_LATENCY);
        abort_run();
      end
      check_word("trap_addr_o", trap_addr, exp_addr);
    end else begin
      assert (!seen) else begin
        $display("Interrupt trap taken although interrupts are masked");
        abort_run();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int    fd;
    int    n;
    int    waited;
    int    line_no;
    string line;
    idle_inputs();
    pc        = '0;
    sw_irq    = 1'b0;
    timer_irq = 1'b0;
    ext_irq   = 1'b0;
    waited    = 0;
    while (rstn !== 1'b1 && waited < RST_TIMEOUT) begin
      @(posedge clk);
      waited = waited + 1;
    end
    assert (rstn === 1'b1) else begin
      $display("Reset was never released");
      abort_run();
    end
    #1;
    fd = $fopen("mtrap_cases.txt", "r");
    assert (fd != 0) else begin
      $display("Cannot open the case file mtrap_cases.txt");
      abort_run();
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line    = "";
      n       = $fgets(line, fd);
      line_no = line_no + 1;
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op, rec_instr, rec_rs1, rec_pc,
                    rec_tval, rec_flags, exp_rdata, exp_trap, exp_addr);
        assert (n == 9) else begin
          $display("Malformed record on line %0d of the case file", line_no);
          abort_run();
        end
        if (op == "irq") begin
          run_irq();
        end else if (op == "instr" || op == "fexc" || op == "lexc") begin
          run_strobe();
        end else begin
          $display("Unknown operation %s on line %0d of the case file", op, line_no);
          abort_run();
        end
      end
    end
    $fclose(fd);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- mtrap_cases.txt
# op instr rs1 pc tval flags exp_rdata exp_trap exp_addr, all hex
# flags bit0 check rdata, bit1 lsu store; irq flags {ext,timer,sw}; lexc instr 0 = no strobe
instr F11020F3 00000000 00000100 00000000 1 00000000 0 00000000
instr F12020F3 00000000 00000104 00000000 1 00000000 0 00000000
instr F13020F3 00000000 00000108 00000000 1 00000001 0 00000000
instr F14020F3 00000000 0000010C 00000000 1 00000000 0 00000000
instr 301020F3 00000000 00000110 00000000 1 40000100 0 00000000
instr 305020F3 00000000 00000114 00000000 1 00000100 0 00000000
instr 340290F3 A5A50F0F 00000118 00000000 1 00000000 0 00000000
instr 3402A0F3 000000F0 0000011C 00000000 1 A5A50F0F 0 00000000
instr 3402B0F3 A5000000 00000120 00000000 1 A5A50FFF 0 00000000
instr 340020F3 FFFFFFFF 00000124 00000000 1 00A50FFF 0 00000000
instr 340020F3 00000000 00000128 00000000 1 00A50FFF 0 00000000
instr 304FD0F3 00000000 0000012C 00000000 1 00000000 0 00000000
instr 304470F3 00000000 00000130 00000000 1 00000008 0 00000000
instr 304FE0F3 00000000 00000134 00000000 1 00000000 0 00000000
instr 3042A0F3 FFFFFFFF 00000138 00000000 1 00000008 0 00000000
instr 304020F3 00000000 0000013C 00000000 1 00000888 0 00000000
instr 305290F3 00002003 00000140 00000000 1 00000100 0 00000000
instr 300460F3 00000000 00000144 00000000 1 00000000 0 00000000
fexc  00000000 00000000 00000444 00000446 0 00000000 1 00002000
instr 341020F3 00000000 00002000 00000000 1 00000444 0 00000000
instr 342020F3 00000000 00002004 00000000 1 00000000 0 00000000
instr 343020F3 00000000 00002008 00000000 1 00000446 0 00000000
instr 300020F3 00000000 0000200C 00000000 1 00000080 0 00000000
lexc  340290F3 12345678 00000500 00000503 3 00A50FFF 1 00002000
instr 342020F3 00000000 00002000 00000000 1 00000006 0 00000000
instr 340020F3 00000000 00002004 00000000 1 00A50FFF 0 00000000
instr 300460F3 00000000 00002008 00000000 1 00000000 0 00000000
irq   00000000 00000000 00000600 00000000 6 00000000 1 00002000
instr 342020F3 00000000 00002000 00000000 1 8000000B 0 00000000
instr 341020F3 00000000 00002004 00000000 1 00000600 0 00000000
instr 300020F3 00000000 00002008 00000000 1 00000080 0 00000000
irq   00000000 00000000 0000200C 00000000 6 00000000 0 00000000
instr 30200073 00000000 00000700 00000000 0 00000000 1 00000600
instr 300020F3 00000000 00000600 00000000 1 00000088 0 00000000

//--- filelist.f
+incdir+.
mtrap_pkg.sv
csr_instr_decoder.sv
trap_ctrl.sv
machine_csr_file.sv
mtrap_top.sv
mtrap_clkgen.sv
mtrap_checker.sv
tb_mtrap.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mtrap testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f filelist.f --top-module tb_mtrap \
  -Mdir "$OBJ" -o vtb_mtrap
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/vtb_mtrap" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0
